//--- pmem_cfg.svh
`ifndef PMEM_CFG_SVH
`define PMEM_CFG_SVH

// port count applies to ingress and egress alike.
`define PMEM_PORTS 2

`define PMEM_SLOTS 8
`define PMEM_BEATS 16 // longer packets keep only their first beats.

`define PMEM_SLOT_W 3
`define PMEM_BEAT_W 4
`define PMEM_PORT_W 1

`define PMEM_DATA_W 64
`define PMEM_EMPTY_W 3 // empty bytes in the last 64-bit beat.

`endif

//--- pmem_pkg.sv
`default_nettype none

`include "pmem_cfg.svh"

package pmem_pkg;

	typedef enum logic {
		SLOT_ALLOC,
		SLOT_COMMIT
	} slot_op_e;

	typedef enum logic [2:0] {
		CTL_IDLE,
		CTL_ALLOC, // closes the handshake of an alloc or a commit.
		CTL_NOTIFY,
		CTL_TAG,
		CTL_RELEASE
	} ctrl_state_e;

	typedef enum logic [2:0] {
		ING_IDLE,
		ING_ALLOC,
		ING_GRANT,
		ING_RECV,
		ING_COMMIT
	} ing_state_e;

	// layout of tagin_data, drop in the top bit.
	typedef struct packed {
		logic drop;
		logic [`PMEM_PORT_W-1:0] port;
		logic [`PMEM_SLOT_W-1:0] slot;
	} pmem_tag_t;

endpackage

`default_nettype wire

//--- pmem_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

interface pmem_slot_if;
	import pmem_pkg::*;

	logic req;
	slot_op_e op;
	logic [`PMEM_BEAT_W-1:0] beats; // stored beats minus one.
	logic [`PMEM_EMPTY_W-1:0] empty;
	logic ack;
	logic [`PMEM_SLOT_W-1:0] slot;

	modport initiator (output req, op, beats, empty, input ack, slot);
	modport target (input req, op, beats, empty, output ack, slot);
endinterface

interface pmem_xmit_if;
	logic req;
	logic [`PMEM_SLOT_W-1:0] slot;
	logic ack;

	modport initiator (output req, slot, input ack);
	modport target (input req, slot, output ack);
endinterface

interface pmem_wr_if;
	logic we;
	logic [`PMEM_SLOT_W-1:0] slot;
	logic [`PMEM_BEAT_W-1:0] beat;
	logic [`PMEM_DATA_W-1:0] data;
	logic last; // records length and empty even when we is low.
	logic [`PMEM_EMPTY_W-1:0] empty;

	modport writer (output we, slot, beat, data, last, empty);
	modport target (input we, slot, beat, data, last, empty);
endinterface

interface pmem_rd_if;
	logic [`PMEM_SLOT_W-1:0] slot;
	logic [`PMEM_BEAT_W-1:0] beat;
	logic [`PMEM_DATA_W-1:0] data;
	logic [`PMEM_BEAT_W-1:0] len;
	logic [`PMEM_EMPTY_W-1:0] empty;

	modport reader (output slot, beat, input data, len, empty);
	modport target (input slot, beat, output data, len, empty);
endinterface

`default_nettype wire

//--- pmem_ingress.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_ingress (
	input  logic clock,
	input  logic rst_n,
	input  logic [`PMEM_DATA_W-1:0] packetin_data,
	input  logic packetin_valid,
	input  logic packetin_sop,
	input  logic packetin_eop,
	input  logic [`PMEM_EMPTY_W-1:0] packetin_empty,
	output logic packetin_ready,
	pmem_slot_if.initiator slot,
	pmem_wr_if.writer wr
);
	import pmem_pkg::*;

	localparam int BEAT_W = `PMEM_BEAT_W;
	localparam int BEATS = `PMEM_BEATS;

	ing_state_e state;
	logic [`PMEM_SLOT_W-1:0] own_slot;
	logic [BEAT_W-1:0] cnt;
	logic [BEAT_W-1:0] beats_q;
	logic [`PMEM_EMPTY_W-1:0] empty_q;
	logic in_pkt;
	logic full;
	logic take;

	assign packetin_ready = (state == ING_RECV);
	assign take = packetin_valid && packetin_ready && (in_pkt || packetin_sop); // stray beats drop.

	assign slot.req = (state == ING_ALLOC) || (state == ING_COMMIT);
	assign slot.op = (state == ING_COMMIT) ? SLOT_COMMIT : SLOT_ALLOC;
	assign slot.beats = beats_q;
	assign slot.empty = empty_q;

	assign wr.we = take && !full; // a full slot keeps its sixteenth beat.
	assign wr.slot = own_slot;
	assign wr.beat = cnt;
	assign wr.data = packetin_data;
	assign wr.last = take && packetin_eop;
	assign wr.empty = packetin_empty;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= ING_IDLE;
			cnt <= '0;
			in_pkt <= 1'b0;
			full <= 1'b0;
		end else begin
			case (state)
				ING_IDLE: if (!slot.ack) state <= ING_ALLOC;
				ING_ALLOC: if (slot.ack) state <= ING_GRANT;
				ING_GRANT: if (!slot.ack) state <= ING_RECV;
				ING_RECV: if (take && packetin_eop) state <= ING_COMMIT;
				ING_COMMIT: if (slot.ack) state <= ING_IDLE;
				default: state <= ING_IDLE;
			endcase
			if (take) begin
				if (packetin_eop) begin
					in_pkt <= 1'b0;
					full <= 1'b0;
					cnt <= '0;
				end else begin
					in_pkt <= 1'b1;
					if (cnt == BEAT_W'(BEATS - 1))
						full <= 1'b1;
					else
						cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == ING_ALLOC && slot.ack)
			own_slot <= slot.slot;
		if (take && packetin_eop) begin
			beats_q <= cnt;
			empty_q <= packetin_empty;
		end
	end

endmodule

`default_nettype wire

//--- pmem_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_buffer (
	input logic clock,
	pmem_wr_if.target wr [`PMEM_PORTS],
	pmem_rd_if.target rd [`PMEM_PORTS+1]
);
	localparam int PORTS = `PMEM_PORTS;

	logic [`PMEM_DATA_W-1:0] mem [`PMEM_SLOTS*`PMEM_BEATS];
	logic [`PMEM_BEAT_W-1:0] len_mem [`PMEM_SLOTS];
	logic [`PMEM_EMPTY_W-1:0] empty_mem [`PMEM_SLOTS];

	logic we [PORTS];
	logic last [PORTS];
	logic [`PMEM_SLOT_W-1:0] wslot [PORTS];
	logic [`PMEM_BEAT_W-1:0] wbeat [PORTS];
	logic [`PMEM_DATA_W-1:0] wdata [PORTS];
	logic [`PMEM_EMPTY_W-1:0] wempty [PORTS];

	for (genvar i = 0; i < PORTS; i++) begin : g_wr
		assign we[i] = wr[i].we;
		assign last[i] = wr[i].last;
		assign wslot[i] = wr[i].slot;
		assign wbeat[i] = wr[i].beat;
		assign wdata[i] = wr[i].data;
		assign wempty[i] = wr[i].empty;
	end

	// each ingress owns its slot, so the write ports never collide.
	always_ff @(posedge clock) begin
		for (int i = 0; i < PORTS; i++) begin
			if (we[i])
				mem[{wslot[i], wbeat[i]}] <= wdata[i];
			if (last[i]) begin
				len_mem[wslot[i]] <= wbeat[i];
				empty_mem[wslot[i]] <= wempty[i];
			end
		end
	end

	for (genvar j = 0; j < PORTS + 1; j++) begin : g_rd
		always_ff @(posedge clock) begin
			rd[j].data <= mem[{rd[j].slot, rd[j].beat}];
			rd[j].len <= len_mem[rd[j].slot];
			rd[j].empty <= empty_mem[rd[j].slot];
		end
	end

endmodule

`default_nettype wire

//--- pmem_egress.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_egress (
	input  logic clock,
	input  logic rst_n,
	pmem_xmit_if.target xmit,
	pmem_rd_if.reader rd,
	output logic [`PMEM_DATA_W-1:0] transmitout_data,
	output logic transmitout_valid,
	output logic transmitout_sop,
	output logic transmitout_eop,
	output logic [`PMEM_EMPTY_W-1:0] transmitout_empty,
	input  logic transmitout_ready
);
	localparam int BEAT_W = `PMEM_BEAT_W;

	logic [BEAT_W:0] next_beat; // the extra bit ends the slot after beat fifteen.
	logic [BEAT_W-1:0] iss_beat;
	logic iss_q;
	logic issue;
	logic pop;
	logic ack_q;
	logic [1:0] cnt;
	logic [2:0] fill;
	logic wptr;
	logic rptr;
	logic [`PMEM_DATA_W-1:0] sk_data [2];
	logic sk_sop [2];
	logic sk_eop [2];
	logic [`PMEM_EMPTY_W-1:0] sk_empty [2];

	assign pop = transmitout_valid && transmitout_ready;
	assign fill = {1'b0, cnt} + {2'b0, iss_q} - {2'b0, pop}; // entries held after this edge.

	// beat 0 goes out before the length is known.
	assign issue = xmit.req && !ack_q && fill < 3'd2
		&& (next_beat == '0 || next_beat <= {1'b0, rd.len});

	assign rd.slot = xmit.slot;
	assign rd.beat = next_beat[BEAT_W-1:0];
	assign xmit.ack = ack_q;

	assign transmitout_valid = (cnt != 2'd0);
	assign transmitout_data = sk_data[rptr];
	assign transmitout_sop = sk_sop[rptr];
	assign transmitout_eop = sk_eop[rptr];
	assign transmitout_empty = sk_empty[rptr];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			next_beat <= '0;
			iss_q <= 1'b0;
			ack_q <= 1'b0;
			cnt <= 2'd0;
			wptr <= 1'b0;
			rptr <= 1'b0;
		end else begin
			iss_q <= issue;
			if (issue)
				next_beat <= next_beat + 1'b1;
			if (iss_q)
				wptr <= ~wptr;
			if (pop)
				rptr <= ~rptr;
			cnt <= cnt + {1'b0, iss_q} - {1'b0, pop};
			if (pop && sk_eop[rptr]) begin
				ack_q <= 1'b1;
			end else if (ack_q && !xmit.req) begin
				ack_q <= 1'b0;
				next_beat <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (issue)
			iss_beat <= rd.beat;
		if (iss_q) begin
			sk_data[wptr] <= rd.data;
			sk_sop[wptr] <= (iss_beat == '0);
			sk_eop[wptr] <= (iss_beat == rd.len);
			sk_empty[wptr] <= (iss_beat == rd.len) ? rd.empty : '0;
		end
	end

endmodule

`default_nettype wire

//--- pmem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_ctrl (
	input  logic clock,
	input  logic rst_n,
	pmem_slot_if.target slot [`PMEM_PORTS],
	pmem_xmit_if.initiator xmit [`PMEM_PORTS],
	pmem_rd_if.reader rd,
	output logic [`PMEM_DATA_W-1:0] packetout_data,
	output logic [`PMEM_SLOT_W-1:0] packetout_channel,
	output logic packetout_valid,
	input  logic packetout_ready,
	input  pmem_pkg::pmem_tag_t tagin_data,
	input  logic tagin_valid,
	output logic tagin_ready
);
	import pmem_pkg::*;

	localparam int PORTS = `PMEM_PORTS;
	localparam int SLOTS = `PMEM_SLOTS;
	localparam int SLOT_W = `PMEM_SLOT_W;
	localparam int PORT_W = `PMEM_PORT_W;

	ctrl_state_e state;
	logic [SLOT_W-1:0] free_q [SLOTS];
	logic [SLOT_W-1:0] head;
	logic [SLOT_W-1:0] tail;
	logic [SLOT_W:0] free_cnt;
	logic [PORT_W-1:0] rr;
	logic [PORT_W-1:0] cur;
	logic s_req [PORTS];
	slot_op_e s_op [PORTS];
	logic [PORTS-1:0] s_ack;
	logic [SLOT_W-1:0] own_slot [PORTS];
	logic [PORTS-1:0] x_req, x_ack, x_busy, x_done, x_pend;
	logic [SLOT_W-1:0] x_slot [PORTS];
	logic [SLOT_W-1:0] p_slot [PORTS];
	pmem_tag_t tag_q;
	logic [SLOT_W-1:0] rel_slot;
	logic rel_egr;
	logic [PORT_W-1:0] rel_port;
	logic [SLOT_W-1:0] note_slot;
	logic note_valid;
	logic alloc_hit, commit_hit, pend_hit;
	logic [PORT_W-1:0] alloc_port, commit_port, pend_port;

	for (genvar i = 0; i < PORTS; i++) begin : g_port
		assign s_req[i] = slot[i].req;
		assign s_op[i] = slot[i].op;
		assign slot[i].ack = s_ack[i];
		assign slot[i].slot = own_slot[i];
		assign xmit[i].req = x_req[i];
		assign xmit[i].slot = x_slot[i];
		assign x_ack[i] = xmit[i].ack;
	end

	// the port at rr is visited last, so it wins.
	always_comb begin
		logic [PORT_W-1:0] p;
		alloc_hit = 1'b0;
		commit_hit = 1'b0;
		pend_hit = 1'b0;
		alloc_port = rr;
		commit_port = rr;
		pend_port = '0;
		for (int k = PORTS - 1; k >= 0; k--) begin
			p = rr + PORT_W'(k);
			if (s_req[p] && !s_ack[p] && s_op[p] == SLOT_ALLOC && free_cnt != '0) begin
				alloc_hit = 1'b1;
				alloc_port = p;
			end
			if (s_req[p] && !s_ack[p] && s_op[p] == SLOT_COMMIT) begin
				commit_hit = 1'b1;
				commit_port = p;
			end
			if (x_pend[k]) begin
				pend_hit = 1'b1;
				pend_port = PORT_W'(k);
			end
		end
	end

	assign tagin_ready = tagin_valid && (state == CTL_IDLE)
		&& !pend_hit && !alloc_hit && !commit_hit;
	assign rd.slot = note_slot;
	assign rd.beat = '0;
	assign packetout_data = rd.data;
	assign packetout_channel = note_slot;
	assign packetout_valid = note_valid;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= CTL_IDLE;
			head <= '0;
			tail <= '0;
			free_cnt <= (SLOT_W + 1)'(SLOTS);
			rr <= '0;
			cur <= '0;
			note_valid <= 1'b0;
			s_ack <= '0;
			x_req <= '0;
			x_busy <= '0;
			x_done <= '0;
			x_pend <= '0;
			for (int i = 0; i < SLOTS; i++)
				free_q[i] <= SLOT_W'(i);
		end else begin
			for (int i = 0; i < PORTS; i++) begin
				if (x_req[i] && x_ack[i]) begin
					x_req[i] <= 1'b0;
					x_done[i] <= 1'b1;
				end
				if (x_done[i] && !x_req[i] && !x_ack[i]) begin // ack has fallen.
					x_done[i] <= 1'b0;
					x_busy[i] <= 1'b0;
					x_pend[i] <= 1'b1;
					p_slot[i] <= x_slot[i];
				end
			end
			case (state)
				CTL_IDLE: begin
					if (pend_hit) begin
						rel_slot <= p_slot[pend_port];
						rel_egr <= 1'b1;
						rel_port <= pend_port;
						state <= CTL_RELEASE;
					end else if (alloc_hit) begin
						own_slot[alloc_port] <= free_q[head];
						head <= head + 1'b1;
						free_cnt <= free_cnt - 1'b1;
						s_ack[alloc_port] <= 1'b1;
						cur <= alloc_port;
						rr <= alloc_port + PORT_W'(1);
						state <= CTL_ALLOC;
					end else if (commit_hit) begin
						note_slot <= own_slot[commit_port];
						cur <= commit_port;
						rr <= commit_port + PORT_W'(1);
						state <= CTL_NOTIFY;
					end else if (tagin_valid) begin
						tag_q <= tagin_data;
						rel_slot <= tagin_data.slot;
						rel_egr <= 1'b0;
						state <= tagin_data.drop ? CTL_RELEASE : CTL_TAG;
					end
				end
				CTL_ALLOC: begin
					if (!s_req[cur]) begin
						s_ack[cur] <= 1'b0;
						state <= CTL_IDLE;
					end
				end
				CTL_NOTIFY: begin
					if (!note_valid) begin
						note_valid <= 1'b1; // beat 0 is out of the buffer by now.
					end else if (packetout_ready) begin
						note_valid <= 1'b0;
						s_ack[cur] <= 1'b1;
						state <= CTL_ALLOC;
					end
				end
				CTL_TAG: begin
					if (!x_busy[tag_q.port]) begin
						x_req[tag_q.port] <= 1'b1;
						x_busy[tag_q.port] <= 1'b1;
						x_slot[tag_q.port] <= tag_q.slot;
						state <= CTL_IDLE;
					end
				end
				CTL_RELEASE: begin
					free_q[tail] <= rel_slot;
					tail <= tail + 1'b1;
					free_cnt <= free_cnt + 1'b1;
					if (rel_egr)
						x_pend[rel_port] <= 1'b0;
					state <= CTL_IDLE;
				end
				default: state <= CTL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- pmem_group.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_group (
	input  logic clock,
	input  logic rst_n,
	input  logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_PORTS],
	input  logic packetin_valid [`PMEM_PORTS],
	input  logic packetin_sop [`PMEM_PORTS],
	input  logic packetin_eop [`PMEM_PORTS],
	input  logic [`PMEM_EMPTY_W-1:0] packetin_empty [`PMEM_PORTS],
	output logic packetin_ready [`PMEM_PORTS],
	output logic [`PMEM_DATA_W-1:0] packetout_data,
	output logic [`PMEM_SLOT_W-1:0] packetout_channel,
	output logic packetout_valid,
	input  logic packetout_ready,
	output logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS],
	output logic transmitout_valid [`PMEM_PORTS],
	output logic transmitout_sop [`PMEM_PORTS],
	output logic transmitout_eop [`PMEM_PORTS],
	output logic [`PMEM_EMPTY_W-1:0] transmitout_empty [`PMEM_PORTS],
	input  logic transmitout_ready [`PMEM_PORTS],
	input  pmem_pkg::pmem_tag_t tagin_data,
	input  logic tagin_valid,
	output logic tagin_ready
);
	pmem_slot_if slot_bus [`PMEM_PORTS] ();
	pmem_xmit_if xmit_bus [`PMEM_PORTS] ();
	pmem_wr_if wr_bus [`PMEM_PORTS] ();
	pmem_rd_if rd_bus [`PMEM_PORTS+1] (); // the last read port serves the notice.

	for (genvar i = 0; i < `PMEM_PORTS; i++) begin : g_port
		pmem_ingress u_ingress (
			.clock (clock),
			.rst_n (rst_n),
			.packetin_data (packetin_data[i]),
			.packetin_valid (packetin_valid[i]),
			.packetin_sop (packetin_sop[i]),
			.packetin_eop (packetin_eop[i]),
			.packetin_empty (packetin_empty[i]),
			.packetin_ready (packetin_ready[i]),
			.slot (slot_bus[i]),
			.wr (wr_bus[i])
		);

		pmem_egress u_egress (
			.clock (clock),
			.rst_n (rst_n),
			.xmit (xmit_bus[i]),
			.rd (rd_bus[i]),
			.transmitout_data (transmitout_data[i]),
			.transmitout_valid (transmitout_valid[i]),
			.transmitout_sop (transmitout_sop[i]),
			.transmitout_eop (transmitout_eop[i]),
			.transmitout_empty (transmitout_empty[i]),
			.transmitout_ready (transmitout_ready[i])
		);
	end

	pmem_buffer u_buffer (
		.clock (clock),
		.wr (wr_bus),
		.rd (rd_bus)
	);

	pmem_ctrl u_ctrl (
		.clock (clock),
		.rst_n (rst_n),
		.slot (slot_bus),
		.xmit (xmit_bus),
		.rd (rd_bus[`PMEM_PORTS]),
		.packetout_data (packetout_data),
		.packetout_channel (packetout_channel),
		.packetout_valid (packetout_valid),
		.packetout_ready (packetout_ready),
		.tagin_data (tagin_data),
		.tagin_valid (tagin_valid),
		.tagin_ready (tagin_ready)
	);

endmodule

`default_nettype wire

//--- pmem_group_asserts.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_group_asserts (
	input logic clock,
	input logic rst_n,
	input logic packetin_ready [`PMEM_PORTS],
	input logic [`PMEM_DATA_W-1:0] packetout_data,
	input logic [`PMEM_SLOT_W-1:0] packetout_channel,
	input logic packetout_valid,
	input logic packetout_ready,
	input logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS],
	input logic transmitout_valid [`PMEM_PORTS],
	input logic transmitout_sop [`PMEM_PORTS],
	input logic transmitout_eop [`PMEM_PORTS],
	input logic [`PMEM_EMPTY_W-1:0] transmitout_empty [`PMEM_PORTS],
	input logic transmitout_ready [`PMEM_PORTS],
	input logic tagin_ready
);

	notice_reset: assert property (@(posedge clock) !rst_n |=> !packetout_valid)
		else $error("packetout_valid is high after reset");

	notice_hold: assert property (@(posedge clock) disable iff (!rst_n)
		packetout_valid && !packetout_ready |=> packetout_valid
			&& $stable(packetout_data) && $stable(packetout_channel))
		else $error("the notice changed while packetout_ready was low");

	// the controller leaves idle once a tag is taken.
	tag_once: assert property (@(posedge clock) disable iff (!rst_n)
		tagin_ready |=> !tagin_ready)
		else $error("tagin_ready was high for two cycles in a row");

	for (genvar i = 0; i < `PMEM_PORTS; i++) begin : g_port
		logic in_pkt;

		always_ff @(posedge clock) begin
			if (!rst_n)
				in_pkt <= 1'b0;
			else if (transmitout_valid[i] && transmitout_ready[i])
				in_pkt <= !transmitout_eop[i];
		end

		out_reset: assert property (@(posedge clock)
			!rst_n |=> !transmitout_valid[i] && !packetin_ready[i])
			else $error("a stream valid or ready is high after reset");

		out_hold: assert property (@(posedge clock) disable iff (!rst_n)
			transmitout_valid[i] && !transmitout_ready[i] |=> transmitout_valid[i]
				&& $stable(transmitout_data[i]) && $stable(transmitout_sop[i])
				&& $stable(transmitout_eop[i]) && $stable(transmitout_empty[i]))
			else $error("an egress beat changed while transmitout_ready was low");

		sop_once: assert property (@(posedge clock) disable iff (!rst_n)
			transmitout_valid[i] && transmitout_sop[i] |-> !in_pkt)
			else $error("an egress sop came before the eop of the previous packet");
	end

endmodule

bind pmem_group pmem_group_asserts u_asserts (
	.clock (clock),
	.rst_n (rst_n),
	.packetin_ready (packetin_ready),
	.packetout_data (packetout_data),
	.packetout_channel (packetout_channel),
	.packetout_valid (packetout_valid),
	.packetout_ready (packetout_ready),
	.transmitout_data (transmitout_data),
	.transmitout_valid (transmitout_valid),
	.transmitout_sop (transmitout_sop),
	.transmitout_eop (transmitout_eop),
	.transmitout_empty (transmitout_empty),
	.transmitout_ready (transmitout_ready),
	.tagin_ready (tagin_ready)
);

`default_nettype wire

//--- pmem_group_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pmem_cfg.svh"

module pmem_group_tb;
	import pmem_pkg::*;

	localparam int PORTS = `PMEM_PORTS;
	localparam int BEATS = `PMEM_BEATS;
	localparam int LIMIT = 4000; // about twice the summed length of the tests.
	localparam int MAXPKT = 64;
	localparam int MAXLEN = 20;
	localparam logic [31:0] SEED = 32'ha93d_3a4f;

	logic clock;
	logic rst_n;
	logic [`PMEM_DATA_W-1:0] packetin_data [`PMEM_PORTS];
	logic packetin_valid [`PMEM_PORTS];
	logic packetin_sop [`PMEM_PORTS];
	logic packetin_eop [`PMEM_PORTS];
	logic [`PMEM_EMPTY_W-1:0] packetin_empty [`PMEM_PORTS];
	logic packetin_ready [`PMEM_PORTS];
	logic [`PMEM_DATA_W-1:0] packetout_data;
	logic [`PMEM_SLOT_W-1:0] packetout_channel;
	logic packetout_valid;
	logic packetout_ready;
	logic [`PMEM_DATA_W-1:0] transmitout_data [`PMEM_PORTS];
	logic transmitout_valid [`PMEM_PORTS];
	logic transmitout_sop [`PMEM_PORTS];
	logic transmitout_eop [`PMEM_PORTS];
	logic [`PMEM_EMPTY_W-1:0] transmitout_empty [`PMEM_PORTS];
	logic transmitout_ready [`PMEM_PORTS];
	pmem_tag_t tagin_data;
	logic tagin_valid;
	logic tagin_ready;

	logic [`PMEM_DATA_W-1:0] pkt_beat [MAXPKT][MAXLEN];
	int pkt_len [MAXPKT];
	logic [`PMEM_EMPTY_W-1:0] pkt_empty [MAXPKT];
	int pkt_mode [MAXPKT]; // 0 or 1 names the egress, 2 drops.
	int pkt_slot [MAXPKT];
	int slot_pkt [`PMEM_SLOTS];
	logic live [`PMEM_SLOTS];
	int notice_id [MAXPKT];
	int exp_fifo [`PMEM_PORTS][MAXPKT];
	int exp_wr [`PMEM_PORTS];
	int exp_rd [`PMEM_PORTS];
	int cur_id [`PMEM_PORTS];
	int cur_beat [`PMEM_PORTS];
	logic active [`PMEM_PORTS];
	int pkt_cnt, notice_cnt, done_cnt, tag_next, cycles;
	int mon_errors, main_errors, tests, failed_tests;
	logic [31:0] rng;
	logic [31:0] gap_rng;
	logic gaps;
	string test_name;

	pmem_group u_pmem_group (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Testbench failed");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		return next_word() % n;
	endfunction

	function automatic int kept_beats(input int len);
		return (len > BEATS) ? BEATS : len; // the rest of a long packet is not stored.
	endfunction

	function automatic int make_packet(input int len, input int mode);
		int id;
		id = pkt_cnt;
		pkt_cnt++;
		pkt_len[id] = len;
		pkt_mode[id] = mode;
		pkt_empty[id] = `PMEM_EMPTY_W'(pick(8));
		for (int b = 0; b < len; b++)
			pkt_beat[id][b] = {next_word(), next_word()};
		pkt_beat[id][0][63:56] = 8'(id); // the notice names its packet.
		return id;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp,
			input logic [63:0] act);
		$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	task automatic report_problem(input string msg);
		$display("Error in %s: %s", test_name, msg);
	endtask

	task automatic send_packet(input int p, input int id);
		for (int b = 0; b < pkt_len[id]; b++) begin
			packetin_data[p] = pkt_beat[id][b];
			packetin_sop[p] = (b == 0);
			packetin_eop[p] = (b == pkt_len[id] - 1);
			packetin_empty[p] = (b == pkt_len[id] - 1) ? pkt_empty[id] : '0;
			packetin_valid[p] = 1'b1;
			do
				@(negedge clock);
			while (!packetin_ready[p]);
			@(posedge clock);
			#1;
		end
		packetin_valid[p] = 1'b0;
	endtask

	task automatic send_stream(input int p, input int n, input bit drops);
		int id;
		int mode;
		for (int k = 0; k < n; k++) begin
			mode = (drops && k % 2 == 0) ? 2 : int'(pick(2));
			id = make_packet(1 + int'(pick(12)), mode);
			send_packet(p, id);
		end
	endtask

	task automatic wait_done(input int target);
		while (done_cnt < target)
			@(negedge clock);
		@(posedge clock);
		#1;
	endtask

	task automatic finish_test(input int errs_before);
		int errs;
		errs = mon_errors + main_errors - errs_before;
		tests++;
		if (errs == 0) begin
			$display("%s: ok", test_name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", test_name, errs);
		end
	endtask

	initial begin
		packetout_ready = 1'b0;
		for (int i = 0; i < PORTS; i++)
			transmitout_ready[i] = 1'b0;
		gap_rng = xorshift(~SEED);
		forever begin
			@(posedge clock);
			#1;
			gap_rng = xorshift(gap_rng);
			packetout_ready = !gaps || gap_rng[1:0] != 2'd0;
			for (int i = 0; i < PORTS; i++)
				transmitout_ready[i] = !gaps || gap_rng[2*i+3 -: 2] != 2'd0;
		end
	end

	// answers each notice in order, as the classifier would.
	initial begin
		int id;
		tagin_valid = 1'b0;
		tagin_data = '0;
		tag_next = 0;
		forever begin
			@(posedge clock);
			#1;
			if (tag_next < notice_cnt) begin
				id = notice_id[tag_next];
				tagin_data.drop = (pkt_mode[id] == 2);
				tagin_data.port = `PMEM_PORT_W'(pkt_mode[id]);
				tagin_data.slot = `PMEM_SLOT_W'(pkt_slot[id]);
				tagin_valid = 1'b1;
				do
					@(negedge clock);
				while (!tagin_ready);
				@(posedge clock);
				#1;
				tagin_valid = 1'b0;
				tag_next++;
			end
		end
	end

	always @(negedge clock) begin
		int id;
		int b;
		logic last;
		if (!rst_n) begin
			notice_cnt = 0;
			done_cnt = 0;
			mon_errors = 0;
			for (int s = 0; s < `PMEM_SLOTS; s++)
				live[s] = 1'b0;
			for (int p = 0; p < PORTS; p++) begin
				active[p] = 1'b0;
				exp_wr[p] = 0;
				exp_rd[p] = 0;
			end
		end else begin
			if (packetout_valid && packetout_ready) begin
				id = int'(packetout_data[63:56]);
				if (id >= pkt_cnt) begin
					report_problem("a notice names no packet that was sent");
					mon_errors++;
				end else begin
					assert (packetout_data == pkt_beat[id][0]) else begin
						report_mismatch("notice data", pkt_beat[id][0], packetout_data);
						mon_errors++;
					end
					assert (!live[packetout_channel]) else begin
						report_problem("a notice names a slot that still holds a packet");
						mon_errors++;
					end
					live[packetout_channel] = 1'b1;
					slot_pkt[packetout_channel] = id;
					pkt_slot[id] = int'(packetout_channel);
					notice_id[notice_cnt] = id;
					notice_cnt++;
				end
			end
			if (tagin_valid && tagin_ready) begin
				id = slot_pkt[tagin_data.slot];
				if (tagin_data.drop) begin
					live[tagin_data.slot] = 1'b0;
					done_cnt++;
				end else begin
					exp_fifo[tagin_data.port][exp_wr[tagin_data.port]] = id;
					exp_wr[tagin_data.port]++;
				end
			end
			for (int p = 0; p < PORTS; p++) begin
				if (transmitout_valid[p] && transmitout_ready[p]) begin
					if (!active[p] && exp_rd[p] == exp_wr[p]) begin
						report_problem("an egress sent a packet that was not tagged for it");
						mon_errors++;
					end else begin
						if (!active[p]) begin
							cur_id[p] = exp_fifo[p][exp_rd[p]];
							exp_rd[p]++;
							cur_beat[p] = 0;
							active[p] = 1'b1;
						end
						id = cur_id[p];
						b = cur_beat[p];
						last = (b == kept_beats(pkt_len[id]) - 1);
						assert (transmitout_data[p] == pkt_beat[id][b]) else begin
							report_mismatch("egress data", pkt_beat[id][b], transmitout_data[p]);
							mon_errors++;
						end
						assert (transmitout_sop[p] == (b == 0)) else begin
							report_mismatch("egress sop", 64'(b == 0), 64'(transmitout_sop[p]));
							mon_errors++;
						end
						assert (transmitout_eop[p] == last) else begin
							report_mismatch("egress eop", 64'(last), 64'(transmitout_eop[p]));
							mon_errors++;
						end
						if (last) begin
							assert (transmitout_empty[p] == pkt_empty[id]) else begin
								report_mismatch("egress empty", 64'(pkt_empty[id]),
									64'(transmitout_empty[p]));
								mon_errors++;
							end
							active[p] = 1'b0;
							live[pkt_slot[id]] = 1'b0;
							done_cnt++;
						end else begin
							cur_beat[p]++;
						end
					end
				end
			end
		end
	end

	initial begin
		int errs_before;
		int id;
		int notices_before;
		int wait_cnt;
		rst_n = 1'b0;
		for (int i = 0; i < PORTS; i++) begin
			packetin_data[i] = '0;
			packetin_valid[i] = 1'b0;
			packetin_sop[i] = 1'b0;
			packetin_eop[i] = 1'b0;
			packetin_empty[i] = '0;
		end
		rng = SEED;
		gaps = 1'b0;
		pkt_cnt = 0;
		tests = 0;
		failed_tests = 0;
		main_errors = 0;
		test_name = "reset";
		repeat (2) @(posedge clock);
		#1;
		rst_n = 1'b1;

		test_name = "reset_and_alloc";
		errs_before = mon_errors + main_errors;
		@(negedge clock);
		assert (!packetout_valid && !transmitout_valid[0] && !transmitout_valid[1]) else begin
			report_problem("a valid output is high right after reset");
			main_errors++;
		end
		wait_cnt = 0;
		while (!(packetin_ready[0] && packetin_ready[1]) && wait_cnt < 20) begin
			@(negedge clock);
			wait_cnt++;
		end
		assert (packetin_ready[0] && packetin_ready[1]) else begin
			report_problem("packetin_ready did not rise on both ingress ports");
			main_errors++;
		end
		@(posedge clock);
		#1;
		finish_test(errs_before);

		test_name = "store_and_notify";
		errs_before = mon_errors + main_errors;
		notices_before = notice_cnt;
		id = make_packet(6, 1);
		send_packet(0, id);
		while (notice_cnt == notices_before)
			@(negedge clock);
		@(posedge clock);
		#1;
		finish_test(errs_before);

		test_name = "forwarding";
		errs_before = mon_errors + main_errors;
		wait_done(pkt_cnt);
		assert (notice_cnt == notices_before + 1) else begin
			report_problem("one packet gave more than one notice");
			main_errors++;
		end
		finish_test(errs_before);

		test_name = "concurrency_backpressure";
		errs_before = mon_errors + main_errors;
		gaps = 1'b1;
		fork
			send_stream(0, 6, 1'b0);
			send_stream(1, 6, 1'b0);
		join
		wait_done(pkt_cnt);
		gaps = 1'b0;
		finish_test(errs_before);

		test_name = "slot_recycling";
		errs_before = mon_errors + main_errors;
		fork
			send_stream(0, 10, 1'b1);
			send_stream(1, 10, 1'b1);
		join
		wait_done(pkt_cnt);
		finish_test(errs_before);

		test_name = "truncation";
		errs_before = mon_errors + main_errors;
		id = make_packet(20, 0);
		send_packet(1, id);
		wait_done(pkt_cnt);
		finish_test(errs_before);

		$display("tests %0d, failed tests %0d, failed checks %0d", tests, failed_tests,
			mon_errors + main_errors);
		if (failed_tests == 0 && mon_errors + main_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
pmem_pkg.sv
pmem_if.sv
pmem_ingress.sv
pmem_buffer.sv
pmem_egress.sv
pmem_ctrl.sv
pmem_group.sv
pmem_group_asserts.sv
pmem_group_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module pmem_group_tb -o pmem_sim
	./obj_dir/pmem_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
